//--- Bender.yml
package:
  name: regReadStage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/regReadPkg.sv
      - verilog/physRegFile.sv
      - verilog/operandBypass.sv
      - verilog/readStageLatch.sv
      - verilog/regReadyTable.sv
      - verilog/regReadStage.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tbRegReadStage.sv

//--- regReadStage.f
+incdir+verilog
verilog/regReadPkg.sv
verilog/physRegFile.sv
verilog/operandBypass.sv
verilog/readStageLatch.sv
verilog/regReadyTable.sv
verilog/regReadStage.sv
sim/tbRegReadStage.sv

//--- sim/tbRegReadStage.sv
// Register file is filled by the first test, so operand checks never see unwritten entries
`timescale 1ns/1ps
`include "regReadParams.svh"

module tbRegReadStage import regReadPkg::*; ();

  typedef struct packed {
    logic [7:0]                         testId;
    logic [`NUM_LANES-1:0]              issueValid;
    physTag_t [`NUM_LANES-1:0]          src1;
    physTag_t [`NUM_LANES-1:0]          src2;
    branchMask_t [`NUM_LANES-1:0]       mask;
    payload_t [`NUM_LANES-1:0]          payload;
    logic [`NUM_LANES-1:0]              wbValid;
    physTag_t [`NUM_LANES-1:0]          wbDest;
    logic                               recover;
    logic                               exception;
    logic                               verified;
    logic                               mispredict;
    checkpointId_t                      checkpoint;
    logic [`NUM_LANES-1:0]              unmapValid;
    physTag_t [`NUM_LANES-1:0]          unmapTag;
    logic [`NUM_LANES-1:0]              wakeValid;
    physTag_t [`NUM_LANES-1:0]          wakeTag;
  } rowT;

  logic                  clk = 1'b0;
  logic                  rstN;
  logic [`NUM_LANES-1:0] issueValid;
  physTag_t              issueSrc1 [`NUM_LANES];
  physTag_t              issueSrc2 [`NUM_LANES];
  branchMask_t           issueMask [`NUM_LANES];
  payload_t              issuePayload [`NUM_LANES];
  logic [`NUM_LANES-1:0] wbValid;
  physTag_t              wbDest [`NUM_LANES];
  regData_t              wbData [`NUM_LANES];
  logic                  recover;
  logic                  exception;
  logic                  ctrlVerified;
  logic                  ctrlMispredict;
  checkpointId_t         ctrlCheckpoint;
  logic [`NUM_LANES-1:0] unmapValid;
  physTag_t              unmapTag [`NUM_LANES];
  logic [`NUM_LANES-1:0] wakeValid;
  physTag_t              wakeTag [`NUM_LANES];
  logic [`NUM_LANES-1:0] exValid;
  regData_t              exOperand1 [`NUM_LANES];
  regData_t              exOperand2 [`NUM_LANES];
  payload_t              exPayload [`NUM_LANES];
  readyVec_t             phyRegRdy;

  rowT       stimRows [$];
  rowT       cur;
  regData_t  shadowRf [`PHYS_REGS];
  readyVec_t shadowRdy;
  integer    seed = 32'hd804453e;

  logic [`NUM_LANES-1:0] expValid;
  logic [`NUM_LANES-1:0] expIssue;
  regData_t              expOp1 [`NUM_LANES];
  regData_t              expOp2 [`NUM_LANES];
  payload_t              expPayload [`NUM_LANES];
  readyVec_t             expRdy;

  int errorCount = 0;
  int checkCount = 0;
  int testErrors = 0;
  int testChecks = 0;
  int testsRun = 0;
  int cycleCount = 0;
  int cycleLimit;

  string testNames [7] = '{"reset state", "fill register file", "write then read",
                           "same cycle bypass", "recover", "squash", "ready table"};

  regReadStage i_regReadStage (
    .clk              (clk),
    .rstN_i           (rstN),
    .issueValid_i     (issueValid),
    .issueSrc1_i      (issueSrc1),
    .issueSrc2_i      (issueSrc2),
    .issueMask_i      (issueMask),
    .issuePayload_i   (issuePayload),
    .wbValid_i        (wbValid),
    .wbDest_i         (wbDest),
    .wbData_i         (wbData),
    .recover_i        (recover),
    .exception_i      (exception),
    .ctrlVerified_i   (ctrlVerified),
    .ctrlMispredict_i (ctrlMispredict),
    .ctrlCheckpoint_i (ctrlCheckpoint),
    .unmapValid_i     (unmapValid),
    .unmapTag_i       (unmapTag),
    .wakeValid_i      (wakeValid),
    .wakeTag_i        (wakeTag),
    .exValid_o        (exValid),
    .exOperand1_o     (exOperand1),
    .exOperand2_o     (exOperand2),
    .exPayload_o      (exPayload),
    .phyRegRdy_o      (phyRegRdy)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic checkValue(string name, logic [63:0] expV, logic [63:0] gotV);
    checkCount++;
    testChecks++;
    if (gotV !== expV) begin
      $display("ERR %s exp %0h got %0h", name, expV, gotV);
      errorCount++;
      testErrors++;
    end
  endtask

  function automatic readyVec_t archPattern();
    readyVec_t v;
    v = '0;
    for (int i = 0; i < `ARCH_REGS; i++) begin
      v[i] = 1'b1;
    end
    return v;
  endfunction

  // Highest writeback lane with a matching destination supplies the operand
  function automatic regData_t operandFor(physTag_t tag, rowT row);
    regData_t v;
    logic     found;
    v = shadowRf[tag];
    found = 1'b0;
    for (int l = `NUM_LANES-1; l >= 0; l--) begin
      if (!found && row.wbValid[l] && row.wbDest[l] == tag) begin
        v = wbData[l];
        found = 1'b1;
      end
    end
    return v;
  endfunction

  task automatic newRow(int testId);
    cur = '0;
    cur.testId = testId;
    for (int l = 0; l < `NUM_LANES; l++) begin
      cur.payload[l] = payload_t'(16'h1000 * (l + 1) + stimRows.size());
    end
  endtask

  task automatic setIssue(logic [3:0] valid, int s1 [4], int s2 [4]);
    cur.issueValid = valid;
    for (int l = 0; l < `NUM_LANES; l++) begin
      cur.src1[l] = physTag_t'(s1[l]);
      cur.src2[l] = physTag_t'(s2[l]);
    end
  endtask

  task automatic setWriteback(logic [3:0] valid, int dest [4]);
    cur.wbValid = valid;
    for (int l = 0; l < `NUM_LANES; l++) begin
      cur.wbDest[l] = physTag_t'(dest[l]);
    end
  endtask

  task automatic setSquash(logic ver, logic misp, int cp, logic [15:0] masks);
    cur.issueValid = 4'b1111;
    cur.verified = ver;
    cur.mispredict = misp;
    cur.checkpoint = checkpointId_t'(cp);
    for (int l = 0; l < `NUM_LANES; l++) begin
      cur.mask[l] = masks[4*l +: 4];
    end
  endtask

  task automatic buildTable();
    for (int i = 0; i < `PHYS_REGS / `NUM_LANES; i++) begin
      newRow(1);
      setWriteback(4'b1111, '{4*i, 4*i+1, 4*i+2, 4*i+3});
      stimRows.push_back(cur);
    end
    newRow(2);
    setWriteback(4'b1111, '{5, 9, 40, 63});
    stimRows.push_back(cur);
    newRow(2);
    setIssue(4'b1111, '{5, 9, 40, 63}, '{63, 40, 9, 5});
    setWriteback(4'b1111, '{1, 2, 3, 4});                   // Unrelated to this row's reads
    stimRows.push_back(cur);
    newRow(2);
    setIssue(4'b1111, '{1, 2, 3, 4}, '{0, 33, 62, 17});
    stimRows.push_back(cur);
    newRow(3);
    setWriteback(4'b1111, '{12, 12, 13, 12});               // Lane 3 must win on tag 12
    setIssue(4'b1111, '{12, 13, 12, 7}, '{13, 12, 20, 12});
    stimRows.push_back(cur);
    newRow(3);
    setIssue(4'b1111, '{12, 13, 12, 13}, '{13, 12, 13, 12});
    stimRows.push_back(cur);
    newRow(4);
    cur.recover = 1'b1;
    setWriteback(4'b1111, '{20, 21, 22, 23});
    setIssue(4'b1111, '{20, 21, 22, 23}, '{23, 22, 21, 20});
    stimRows.push_back(cur);
    newRow(4);
    setIssue(4'b1111, '{20, 21, 22, 23}, '{23, 22, 21, 20});
    stimRows.push_back(cur);
    newRow(5);
    setSquash(1'b1, 1'b1, 2, 16'b1011_1111_0000_0100);      // Kills lanes 0 and 2
    stimRows.push_back(cur);
    newRow(5);
    setSquash(1'b0, 1'b1, 2, 16'b1011_1111_0000_0100);
    stimRows.push_back(cur);
    newRow(5);
    setSquash(1'b1, 1'b0, 2, 16'b1011_1111_0000_0100);
    stimRows.push_back(cur);
    newRow(5);
    setSquash(1'b1, 1'b1, 0, 16'b1000_0100_0010_0001);
    cur.issueValid = 4'b1011;
    stimRows.push_back(cur);
    newRow(6);
    cur.unmapValid = 4'b0011;
    cur.unmapTag[0] = 6'd3;
    cur.unmapTag[1] = 6'd7;
    cur.wakeValid = 4'b0001;
    cur.wakeTag[0] = 6'd40;
    stimRows.push_back(cur);
    newRow(6);
    cur.unmapValid = 4'b0111;
    cur.unmapTag[0] = 6'd10;
    cur.unmapTag[1] = 6'd20;
    cur.unmapTag[2] = 6'd50;
    cur.wakeValid = 4'b0111;
    cur.wakeTag[0] = 6'd3;
    cur.wakeTag[1] = 6'd20;
    cur.wakeTag[2] = 6'd50;                                 // Set and clear on 50 together
    stimRows.push_back(cur);
    newRow(6);
    cur.exception = 1'b1;
    cur.unmapValid = 4'b0001;
    cur.unmapTag[0] = 6'd1;
    cur.wakeValid = 4'b0001;
    cur.wakeTag[0] = 6'd60;
    stimRows.push_back(cur);
    newRow(6);
    stimRows.push_back(cur);
  endtask

  task automatic driveIdle();
    issueValid = '0;
    wbValid = '0;
    unmapValid = '0;
    wakeValid = '0;
    recover = 1'b0;
    exception = 1'b0;
    ctrlVerified = 1'b0;
    ctrlMispredict = 1'b0;
    ctrlCheckpoint = '0;
    for (int l = 0; l < `NUM_LANES; l++) begin
      issueSrc1[l] = '0;
      issueSrc2[l] = '0;
      issueMask[l] = '0;
      issuePayload[l] = '0;
      wbDest[l] = '0;
      wbData[l] = '0;
      unmapTag[l] = '0;
      wakeTag[l] = '0;
    end
  endtask

  // Drives one row and predicts what the stage shows after the next rising edge
  task automatic applyRow(rowT row);
    issueValid = row.issueValid;
    wbValid = row.wbValid;
    unmapValid = row.unmapValid;
    wakeValid = row.wakeValid;
    recover = row.recover;
    exception = row.exception;
    ctrlVerified = row.verified;
    ctrlMispredict = row.mispredict;
    ctrlCheckpoint = row.checkpoint;
    for (int l = 0; l < `NUM_LANES; l++) begin
      issueSrc1[l] = row.src1[l];
      issueSrc2[l] = row.src2[l];
      issueMask[l] = row.mask[l];
      issuePayload[l] = row.payload[l];
      wbDest[l] = row.wbDest[l];
      wbData[l] = $random(seed);
      unmapTag[l] = row.unmapTag[l];
      wakeTag[l] = row.wakeTag[l];
    end
    expIssue = row.issueValid;
    for (int l = 0; l < `NUM_LANES; l++) begin
      expValid[l] = row.issueValid[l] &&
                    !(row.verified && row.mispredict && row.mask[l][row.checkpoint]);
      expOp1[l] = operandFor(row.src1[l], row);
      expOp2[l] = operandFor(row.src2[l], row);
      expPayload[l] = row.payload[l];
    end
    if (!row.recover) begin
      for (int l = 0; l < `NUM_LANES; l++) begin
        if (row.wbValid[l]) begin
          shadowRf[row.wbDest[l]] = wbData[l];
        end
      end
    end
    if (row.exception) begin
      shadowRdy = archPattern();
    end else begin
      for (int l = 0; l < `NUM_LANES; l++) begin
        if (row.unmapValid[l]) shadowRdy[row.unmapTag[l]] = 1'b0;
      end
      for (int l = 0; l < `NUM_LANES; l++) begin
        if (row.wakeValid[l]) shadowRdy[row.wakeTag[l]] = 1'b1;
      end
    end
    expRdy = shadowRdy;
  endtask

  task automatic checkOutputs();
    checkValue("exValid_o", 64'(expValid), 64'(exValid));
    checkValue("phyRegRdy_o", expRdy, phyRegRdy);
    for (int l = 0; l < `NUM_LANES; l++) begin
      if (expIssue[l]) begin                                // Data is only meaningful when issued
        checkValue($sformatf("exOperand1_o[%0d]", l), 64'(expOp1[l]), 64'(exOperand1[l]));
        checkValue($sformatf("exOperand2_o[%0d]", l), 64'(expOp2[l]), 64'(exOperand2[l]));
        checkValue($sformatf("exPayload_o[%0d]", l), 64'(expPayload[l]), 64'(exPayload[l]));
      end
    end
  endtask

  task automatic reportTest(int id);
    $display("Test %0d %s: %0d checks, %0d errors", id, testNames[id], testChecks, testErrors);
    testsRun++;
    testChecks = 0;
    testErrors = 0;
  endtask

  initial begin
    rstN = 1'b0;
    driveIdle();
    buildTable();
    cycleLimit = stimRows.size() + 20;
    shadowRdy = archPattern();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    checkValue("exValid_o", 64'd0, 64'(exValid));
    checkValue("phyRegRdy_o", archPattern(), phyRegRdy);
    reportTest(0);
    for (int r = 0; r <= stimRows.size(); r++) begin
      if (r > 0) begin
        checkOutputs();
        if (r == stimRows.size()) begin
          reportTest(stimRows[r-1].testId);
        end else if (stimRows[r].testId != stimRows[r-1].testId) begin
          reportTest(stimRows[r-1].testId);
        end
      end
      if (r < stimRows.size()) begin
        applyRow(stimRows[r]);
        @(negedge clk);
      end
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", testsRun, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verilog/operandBypass.sv
// Purely combinational; forwarding ignores recover so wrong-path data still reaches its consumers
`timescale 1ns/1ps
`include "regReadParams.svh"

module operandBypass import regReadPkg::*; (
  input  physTag_t              readTag_i [2*`NUM_LANES],
  input  regData_t              readData_i [2*`NUM_LANES],
  input  logic [`NUM_LANES-1:0] wbValid_i,
  input  physTag_t              wbDest_i [`NUM_LANES],
  input  regData_t              wbData_i [`NUM_LANES],
  output regData_t              operand_o [2*`NUM_LANES]
);

  logic [`NUM_LANES-1:0] hit [2*`NUM_LANES];     // Bit l set when writeback lane l matches

  for (genvar r = 0; r < 2*`NUM_LANES; r++) begin : gOperand

    for (genvar l = 0; l < `NUM_LANES; l++) begin : gLane
      assign hit[r][l] = wbValid_i[l] && (wbDest_i[l] == readTag_i[r]);
    end

    // Later lanes overwrite earlier ones, giving the highest lane priority
    always_comb begin
      operand_o[r] = readData_i[r];
      for (int l = 0; l < `NUM_LANES; l++) begin
        if (hit[r][l]) begin
          operand_o[r] = wbData_i[l];
        end
      end
    end

  end

endmodule

//--- verilog/physRegFile.sv
// Contents are undefined until written; a write is readable only from the cycle after its edge
`timescale 1ns/1ps
`include "regReadParams.svh"

module physRegFile import regReadPkg::*; (
  input  logic                  clk,
  input  logic [`NUM_LANES-1:0] wbValid_i,
  input  logic                  recover_i,
  input  physTag_t              wbDest_i [`NUM_LANES],
  input  regData_t              wbData_i [`NUM_LANES],
  input  physTag_t              readTag_i [2*`NUM_LANES],
  output regData_t              readData_o [2*`NUM_LANES]
);

  regData_t regFile [`PHYS_REGS];

  logic [`NUM_LANES-1:0] writeEn;

  // Writebacks on the wrong path must not reach the architectural copy
  assign writeEn = wbValid_i & {`NUM_LANES{~recover_i}};

  // Four write ports. The loop runs from lane 0 upward, so when two
  // lanes name the same register the higher lane's data is kept
  always_ff @(posedge clk) begin
    for (int l = 0; l < `NUM_LANES; l++) begin
      if (writeEn[l]) begin
        regFile[wbDest_i[l]] <= wbData_i[l];
      end
    end
  end

  // Eight combinational read ports, two per lane
  for (genvar r = 0; r < 2*`NUM_LANES; r++) begin : gRead
    assign readData_o[r] = regFile[readTag_i[r]];  // No same-cycle write forwarding here
  end

endmodule

//--- verilog/readStageLatch.sv
// Squash uses only the branch resolved in the same cycle as the issue; operands and payload have no reset
`timescale 1ns/1ps
`include "regReadParams.svh"

module readStageLatch import regReadPkg::*; (
  input  logic                  clk,
  input  logic                  rstN_i,
  input  logic [`NUM_LANES-1:0] issueValid_i,
  input  branchMask_t           issueMask_i [`NUM_LANES],
  input  payload_t              issuePayload_i [`NUM_LANES],
  input  regData_t              operand_i [2*`NUM_LANES],
  input  logic                  ctrlVerified_i,
  input  logic                  ctrlMispredict_i,
  input  checkpointId_t         ctrlCheckpoint_i,
  output logic [`NUM_LANES-1:0] exValid_o,
  output regData_t              exOperand1_o [`NUM_LANES],
  output regData_t              exOperand2_o [`NUM_LANES],
  output payload_t              exPayload_o [`NUM_LANES]
);

  logic                  mispredict;
  logic [`NUM_LANES-1:0] squash;
  logic [`NUM_LANES-1:0] validNext;

  assign mispredict = ctrlVerified_i & ctrlMispredict_i;   // Unverified outcomes never kill

  for (genvar l = 0; l < `NUM_LANES; l++) begin : gSquash
    // Kill the lane if it depends on the checkpoint being rolled back
    assign squash[l] = mispredict & issueMask_i[l][ctrlCheckpoint_i];
  end

  assign validNext = issueValid_i & ~squash;

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      exValid_o <= '0;
    end else begin
      exValid_o <= validNext;
    end
  end

  // Data side is captured every cycle and qualified by exValid_o downstream
  always_ff @(posedge clk) begin
    for (int l = 0; l < `NUM_LANES; l++) begin
      exOperand1_o[l] <= operand_i[2*l];
      exOperand2_o[l] <= operand_i[2*l+1];
      exPayload_o[l]  <= issuePayload_i[l];
    end
  end

endmodule

//--- verilog/regReadParams.svh
// Sizes are fixed for a four-wide core; the register file port count assumes NUM_LANES is 4
`ifndef REG_READ_PARAMS_SVH
`define REG_READ_PARAMS_SVH

// Issue and writeback lanes per cycle
`define NUM_LANES 4

// Physical register file geometry
`define PHYS_REGS 64           // Entries in the register file and ready table
`define PHYS_LOG 6             // Tag width, log2 of PHYS_REGS

// Operand width of one register
`define DATA_WIDTH 32

// Branch checkpoints tracked by the mask
`define CHECKPOINTS 4          // One mask bit per checkpoint
`define CHECKPOINTS_LOG 2      // Width of a resolved checkpoint id

// Registers holding committed architectural state after reset
`define ARCH_REGS 32           // Tags 0 to ARCH_REGS-1 start ready

// Instruction fields carried unchanged to execute
`define PAYLOAD_WIDTH 16

`endif

//--- verilog/regReadPkg.sv
// Widths come from the parameter header; changing them there changes every type below
`include "regReadParams.svh"

package regReadPkg;

  // Physical register tag, used for sources, writeback destinations and wakeups
  typedef logic [`PHYS_LOG-1:0] physTag_t;

  // One operand value as read from the register file or a writeback bus
  typedef logic [`DATA_WIDTH-1:0] regData_t;

  // Set bit means the instruction sits behind that branch checkpoint
  typedef logic [`CHECKPOINTS-1:0] branchMask_t;

  // Checkpoint of the branch that resolved this cycle
  typedef logic [`CHECKPOINTS_LOG-1:0] checkpointId_t;

  // Opaque instruction fields passed through to execute
  typedef logic [`PAYLOAD_WIDTH-1:0] payload_t;

  // One ready bit per physical register
  typedef logic [`PHYS_REGS-1:0] readyVec_t;

endpackage

//--- verilog/regReadStage.sv
// One cycle from issue to execute with no back-pressure; downstream must accept every cycle
`timescale 1ns/1ps
`include "regReadParams.svh"

module regReadStage import regReadPkg::*; (
  input  logic                  clk,
  input  logic                  rstN_i,
  // Issue packets, one per lane
  input  logic [`NUM_LANES-1:0] issueValid_i,
  input  physTag_t              issueSrc1_i [`NUM_LANES],
  input  physTag_t              issueSrc2_i [`NUM_LANES],
  input  branchMask_t           issueMask_i [`NUM_LANES],
  input  payload_t              issuePayload_i [`NUM_LANES],
  // Writeback buses
  input  logic [`NUM_LANES-1:0] wbValid_i,
  input  physTag_t              wbDest_i [`NUM_LANES],
  input  regData_t              wbData_i [`NUM_LANES],
  input  logic                  recover_i,
  input  logic                  exception_i,
  // Branch resolution
  input  logic                  ctrlVerified_i,
  input  logic                  ctrlMispredict_i,
  input  checkpointId_t         ctrlCheckpoint_i,
  // Ready table updates
  input  logic [`NUM_LANES-1:0] unmapValid_i,
  input  physTag_t              unmapTag_i [`NUM_LANES],
  input  logic [`NUM_LANES-1:0] wakeValid_i,
  input  physTag_t              wakeTag_i [`NUM_LANES],
  // Toward execute
  output logic [`NUM_LANES-1:0] exValid_o,
  output regData_t              exOperand1_o [`NUM_LANES],
  output regData_t              exOperand2_o [`NUM_LANES],
  output payload_t              exPayload_o [`NUM_LANES],
  output readyVec_t             phyRegRdy_o
);

  physTag_t readTag [2*`NUM_LANES];      // Even entries are source 1, odd are source 2
  regData_t readData [2*`NUM_LANES];
  regData_t operand [2*`NUM_LANES];

  for (genvar l = 0; l < `NUM_LANES; l++) begin : gReadPort
    assign readTag[2*l]   = issueSrc1_i[l];
    assign readTag[2*l+1] = issueSrc2_i[l];
  end

  physRegFile i_physRegFile (
    .clk        (clk),
    .wbValid_i  (wbValid_i),
    .recover_i  (recover_i),
    .wbDest_i   (wbDest_i),
    .wbData_i   (wbData_i),
    .readTag_i  (readTag),
    .readData_o (readData)
  );

  operandBypass i_operandBypass (
    .readTag_i  (readTag),
    .readData_i (readData),
    .wbValid_i  (wbValid_i),
    .wbDest_i   (wbDest_i),
    .wbData_i   (wbData_i),
    .operand_o  (operand)
  );

  readStageLatch i_readStageLatch (
    .clk              (clk),
    .rstN_i           (rstN_i),
    .issueValid_i     (issueValid_i),
    .issueMask_i      (issueMask_i),
    .issuePayload_i   (issuePayload_i),
    .operand_i        (operand),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlMispredict_i (ctrlMispredict_i),
    .ctrlCheckpoint_i (ctrlCheckpoint_i),
    .exValid_o        (exValid_o),
    .exOperand1_o     (exOperand1_o),
    .exOperand2_o     (exOperand2_o),
    .exPayload_o      (exPayload_o)
  );

  regReadyTable i_regReadyTable (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .exception_i  (exception_i),
    .unmapValid_i (unmapValid_i),
    .unmapTag_i   (unmapTag_i),
    .wakeValid_i  (wakeValid_i),
    .wakeTag_i    (wakeTag_i),
    .phyRegRdy_o  (phyRegRdy_o)
  );

endmodule

//--- verilog/regReadyTable.sv
// Updates show one cycle later; a wake beats an unmap of the same tag, and exception restores reset state
`timescale 1ns/1ps
`include "regReadParams.svh"

module regReadyTable import regReadPkg::*; (
  input  logic                  clk,
  input  logic                  rstN_i,
  input  logic                  exception_i,
  input  logic [`NUM_LANES-1:0] unmapValid_i,
  input  physTag_t              unmapTag_i [`NUM_LANES],
  input  logic [`NUM_LANES-1:0] wakeValid_i,
  input  physTag_t              wakeTag_i [`NUM_LANES],
  output readyVec_t             phyRegRdy_o
);

  readyVec_t rdyQ;
  readyVec_t rdyNext;
  readyVec_t restorePattern;

  // Architectural registers hold valid values, renamed ones wait for a producer
  always_comb begin
    for (int i = 0; i < `PHYS_REGS; i++) begin
      restorePattern[i] = (i < `ARCH_REGS);
    end
  end

  // Clears go first so a set on the same tag overrides them
  always_comb begin
    rdyNext = rdyQ;
    for (int l = 0; l < `NUM_LANES; l++) begin
      if (unmapValid_i[l]) begin
        rdyNext[unmapTag_i[l]] = 1'b0;
      end
    end
    for (int l = 0; l < `NUM_LANES; l++) begin
      if (wakeValid_i[l]) begin
        rdyNext[wakeTag_i[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i || exception_i) begin
      rdyQ <= restorePattern;
    end else begin
      rdyQ <= rdyNext;
    end
  end

  assign phyRegRdy_o = rdyQ;

endmodule
